/* rtl/soc_params.svh */
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Bus geometry, one 32-bit Wishbone word per access
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_SEL_W 4

// Main RAM row, two bus words per row
`define SOC_ROW_W 64

// 1024 rows of 8 bytes, 8 KB in all
`define SOC_RAM_ROWS 1024

// Boot image length in bus words
`define SOC_BOOT_WORDS 16

// Byte address of boot word 0
`define SOC_BOOT_BASE 0

`endif

/* rtl/soc_pkg.sv */
`include "soc_params.svh"

package soc_pkg;

	// Byte address on the memory bus
	typedef logic [`SOC_ADDR_W-1:0] bus_addr_t;

	// One bus data word
	typedef logic [`SOC_DATA_W-1:0] bus_data_t;

	// Byte selects, one per byte lane of a bus word
	typedef logic [`SOC_SEL_W-1:0] bus_sel_t;

	// One row of main RAM
	typedef logic [`SOC_ROW_W-1:0] ram_row_t;

	// Word i of the boot image
	// Upper half is a fixed tag, lower half repeats the index in both bytes
	function automatic bus_data_t boot_word(input int unsigned i);
		logic [15:0] low_half;
		low_half = 16'(i) * 16'h0101;
		return {16'hB007, low_half};
	endfunction

endpackage

/* rtl/mem_bus_if.sv */
// Wishbone classic bus between masters, arbiter and RAM
interface mem_bus_if import soc_pkg::*; ();

	// Cycle and strobe rise together
	logic cyc;
	logic stb;
	// 1 for write, 0 for read
	logic we;
	bus_addr_t adr;
	bus_sel_t sel;
	bus_data_t dat_w;

	// Read data, valid only with ack
	bus_data_t dat_r;
	// One cycle pulse that ends an access
	logic ack;

	// Request side
	modport master (
		output cyc,
		output stb,
		output we,
		output adr,
		output sel,
		output dat_w,
		input dat_r,
		input ack
	);

	// Response side
	modport slave (
		input cyc,
		input stb,
		input we,
		input adr,
		input sel,
		input dat_w,
		output dat_r,
		output ack
	);

endinterface

/* rtl/iboot_loader.sv */
`include "soc_params.svh"

// Copies the boot image into main RAM after reset
module iboot_loader import soc_pkg::*; (
	input logic clock_main,
	input logic rst_n,
	mem_bus_if.master bus,
	output logic boot_done
);

	// Wide enough for the last index, one bit at least
	localparam int CNT_W = (`SOC_BOOT_WORDS > 1) ? $clog2(`SOC_BOOT_WORDS) : 1;
	localparam int LAST_WORD = `SOC_BOOT_WORDS - 1;

	// Index of the word being written
	logic [CNT_W-1:0] word_cnt;
	// Request in flight
	logic active;
	// Whole image written
	logic done;
	// Byte address of the current word
	bus_addr_t word_adr;

	// Word i sits at base plus 4 times i
	assign word_adr = bus_addr_t'(`SOC_BOOT_BASE) + (bus_addr_t'(word_cnt) << 2);

	always_ff @(posedge clock_main) begin
		if (!rst_n) begin
			word_cnt <= '0;
			active <= 1'b0;
			done <= 1'b0;
		end else if (!active && !done) begin
			// First cycle out of reset, start the copy
			active <= 1'b1;
		end else if (active && bus.ack) begin
			if (word_cnt == CNT_W'(LAST_WORD)) begin
				// Last word accepted, release the bus for good
				active <= 1'b0;
				done <= 1'b1;
			end else begin
				// Next word, request stays up
				word_cnt <= word_cnt + 1'b1;
			end
		end
	end

	// Request is held steady until ack
	assign bus.cyc = active;
	assign bus.stb = active;
	// Writes only
	assign bus.we = 1'b1;
	assign bus.adr = word_adr;
	// Full word every time
	assign bus.sel = '1;
	assign bus.dat_w = boot_word(word_cnt);

	// Rises the cycle after the last ack and stays until reset
	assign boot_done = done;

endmodule

/* rtl/mem_arbiter.sv */
// Fixed-priority arbiter, boot loader over host
// Grant is held for one whole access, from request to ack
module mem_arbiter import soc_pkg::*; (
	input logic clock_main,
	input logic rst_n,
	mem_bus_if.slave boot_bus,
	mem_bus_if.slave host_bus,
	mem_bus_if.master ram_bus
);

	// Access granted and waiting for ack
	logic busy;
	// Registered owner, 1 when the host holds the grant
	logic owner_host;
	// Idle choice, loader wins whenever it asks
	logic pick_host;
	// Owner seen by the muxes this cycle
	logic sel_host;

	// Muxed request toward the RAM
	logic req_cyc;
	logic req_stb;
	logic req_we;
	bus_addr_t req_adr;
	bus_sel_t req_sel;
	bus_data_t req_dat;

	// Loader has priority until it lets go of cyc
	assign pick_host = !boot_bus.cyc;

	// Choice is combinational while idle, then frozen
	assign sel_host = busy ? owner_host : pick_host;

	always_comb begin
		if (sel_host) begin
			req_cyc = host_bus.cyc;
			req_stb = host_bus.stb;
			req_we = host_bus.we;
			req_adr = host_bus.adr;
			req_sel = host_bus.sel;
			req_dat = host_bus.dat_w;
		end else begin
			req_cyc = boot_bus.cyc;
			req_stb = boot_bus.stb;
			req_we = boot_bus.we;
			req_adr = boot_bus.adr;
			req_sel = boot_bus.sel;
			req_dat = boot_bus.dat_w;
		end
	end

	always_ff @(posedge clock_main) begin
		if (!rst_n) begin
			busy <= 1'b0;
			owner_host <= 1'b0;
		end else if (!busy) begin
			// Lock the owner when its request reaches the RAM
			if (req_cyc && req_stb) begin
				busy <= 1'b1;
				owner_host <= pick_host;
			end
		end else if (ram_bus.ack) begin
			// Access over, back to idle next cycle
			busy <= 1'b0;
		end
	end

	// Request to the RAM
	assign ram_bus.cyc = req_cyc;
	assign ram_bus.stb = req_stb;
	assign ram_bus.we = req_we;
	assign ram_bus.adr = req_adr;
	assign ram_bus.sel = req_sel;
	assign ram_bus.dat_w = req_dat;

	// Response goes to the owner only
	// The other master sees no ack and keeps waiting
	assign boot_bus.ack = ram_bus.ack && !sel_host;
	assign host_bus.ack = ram_bus.ack && sel_host;
	assign boot_bus.dat_r = sel_host ? '0 : ram_bus.dat_r;
	assign host_bus.dat_r = sel_host ? ram_bus.dat_r : '0;

endmodule

/* rtl/main_ram.sv */
`include "soc_params.svh"

// 64-bit byte-enabled RAM behind a 32-bit Wishbone slave
module main_ram import soc_pkg::*; (
	input logic clock_main,
	input logic rst_n,
	mem_bus_if.slave bus
);

	localparam int ROW_AW = $clog2(`SOC_RAM_ROWS);

	ram_row_t mem [`SOC_RAM_ROWS];

	// Row index from bits 12..3, upper bits wrap
	logic [ROW_AW-1:0] row_idx;
	// Bit 2 picks the upper half of the row
	logic upper;
	// Byte enables across the full row
	logic [7:0] byte_en;
	// Write word copied onto both halves
	ram_row_t wr_row;
	// New request accepted this cycle
	logic take;
	logic ack_q;
	// Read half, registered with ack
	bus_data_t rd_q;

	assign row_idx = bus.adr[ROW_AW+2:3];
	assign upper = bus.adr[2];
	assign wr_row = {bus.dat_w, bus.dat_w};

	// Steer the four selects onto the addressed half
	assign byte_en = upper ? {bus.sel, 4'b0000} : {4'b0000, bus.sel};

	// Request in the ack cycle is ignored
	assign take = bus.cyc && bus.stb && !ack_q;

	always_ff @(posedge clock_main) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= take;
		end
	end

	// Storage and read port, no reset
	always_ff @(posedge clock_main) begin
		if (take) begin
			rd_q <= upper ? mem[row_idx][63:32] : mem[row_idx][31:0];
			if (bus.we) begin
				// Only enabled bytes change
				for (int b = 0; b < 8; b++) begin
					if (byte_en[b]) begin
						mem[row_idx][b*8 +: 8] <= wr_row[b*8 +: 8];
					end
				end
			end
		end
	end

	assign bus.ack = ack_q;
	assign bus.dat_r = rd_q;

endmodule

/* rtl/soc_top.sv */
// Memory side of the system: boot loader, host port, arbiter and main RAM
module soc_top import soc_pkg::*; (
	input logic clock_main,
	input logic rst_n,
	// Host port, Wishbone classic
	input logic host_cyc,
	input logic host_stb,
	input logic host_we,
	input bus_addr_t host_adr,
	input bus_sel_t host_sel,
	input bus_data_t host_dat_w,
	output bus_data_t host_dat_r,
	output logic host_ack,
	// Boot image in RAM
	output logic boot_done
);

	// Loader to arbiter
	mem_bus_if loader_bus ();
	// Host ports to arbiter
	mem_bus_if host_bus ();
	// Arbiter to RAM
	mem_bus_if ram_bus ();

	// Host request onto its bus
	assign host_bus.cyc = host_cyc;
	assign host_bus.stb = host_stb;
	assign host_bus.we = host_we;
	assign host_bus.adr = host_adr;
	assign host_bus.sel = host_sel;
	assign host_bus.dat_w = host_dat_w;

	// Host response back out
	assign host_dat_r = host_bus.dat_r;
	assign host_ack = host_bus.ack;

	// Holds the RAM until the image is written
	iboot_loader i_iboot_loader (
		.clock_main(clock_main),
		.rst_n(rst_n),
		.bus(loader_bus.master),
		.boot_done(boot_done)
	);

	// Loader first, host after boot
	mem_arbiter i_mem_arbiter (
		.clock_main(clock_main),
		.rst_n(rst_n),
		.boot_bus(loader_bus.slave),
		.host_bus(host_bus.slave),
		.ram_bus(ram_bus.master)
	);

	// Shared main RAM
	main_ram i_main_ram (
		.clock_main(clock_main),
		.rst_n(rst_n),
		.bus(ram_bus.slave)
	);

endmodule

/* test/clock_gen.sv */
// Free-running testbench clock and power-on reset
module clock_gen (
	output logic clock_main,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	// 20 ns period
	localparam int HALF_PERIOD = 10;

	initial begin
		clock_main = 1'b0;
		forever #(HALF_PERIOD) clock_main = ~clock_main;
	end

	// Low over two rising edges, released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clock_main);
		@(negedge clock_main);
		rst_n = 1'b1;
	end

endmodule

/* test/tb_soc.sv */
`include "soc_params.svh"

// Testbench for the memory side: boot copy, host access, byte lanes
module tb_soc import soc_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 20;
	localparam int unsigned SEED = 32'hf3de_6ba5;
	// Model covers address bits 12..2, the RAM wraps above that
	localparam int REF_WORDS = 2048;
	localparam int FILL_WORDS = 8;
	localparam int RAND_OPS = 200;
	// Random word indices stay in the low 128 words
	localparam int RAND_SPAN = 128;
	// Loader writes plus host accesses of all tests
	localparam int ACCESSES = `SOC_BOOT_WORDS + 1 + `SOC_BOOT_WORDS + 2 * FILL_WORDS
		+ 18 + 6 + RAND_OPS;
	localparam int TIMEOUT_NS = (3 * ACCESSES + 200) * CLK_PERIOD;

	logic clock_main;
	logic rst_n;
	logic host_cyc;
	logic host_stb;
	logic host_we;
	bus_addr_t host_adr;
	bus_sel_t host_sel;
	bus_data_t host_dat_w;
	bus_data_t host_dat_r;
	logic host_ack;
	logic boot_done;

	// Reference memory, one entry per 32-bit word
	bus_data_t ref_mem [REF_WORDS];
	bit ref_known [REF_WORDS];

	int err_count;
	int checks_done;
	int err_mark;
	int acks_seen;
	int acks_issued;
	int tests_run;
	int tests_failed;

	clock_gen i_clock_gen (
		.clock_main(clock_main),
		.rst_n(rst_n)
	);

	soc_top i_soc_top (
		.clock_main(clock_main),
		.rst_n(rst_n),
		.host_cyc(host_cyc),
		.host_stb(host_stb),
		.host_we(host_we),
		.host_adr(host_adr),
		.host_sel(host_sel),
		.host_dat_w(host_dat_w),
		.host_dat_r(host_dat_r),
		.host_ack(host_ack),
		.boot_done(boot_done)
	);

	// Boot image rule: tag B007 over the index repeated in both low bytes
	function automatic bus_data_t image_word(input int i);
		logic [7:0] idx;
		idx = i[7:0];
		return {16'hb007, idx, idx};
	endfunction

	// Expected read data, row and half from bits 12..2
	function automatic bus_data_t ref_read(input bus_addr_t adr);
		return ref_mem[adr[12:2]];
	endfunction

	task automatic ref_write(input bus_addr_t adr, input bus_sel_t sel, input bus_data_t dat);
		bus_data_t word;
		word = ref_mem[adr[12:2]];
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				word[b*8 +: 8] = dat[b*8 +: 8];
			end
		end
		ref_mem[adr[12:2]] = word;
		// Word fully defined once all four bytes were written
		if (sel == 4'hf) begin
			ref_known[adr[12:2]] = 1'b1;
		end
	endtask

	task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
		checks_done++;
		if (got !== exp) begin
			err_count++;
			$display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks_done++;
		if (got !== exp) begin
			err_count++;
			$display("mismatch at %0d ns: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks_done++;
		if (got != exp) begin
			err_count++;
			$display("mismatch at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	// Each host ack ends one access
	// Reads compared here, writes update the model
	always @(negedge clock_main) begin
		if (rst_n && host_ack) begin
			acks_seen++;
			// No host access may finish while the loader still owns the RAM
			check_flag("boot_done", boot_done, 1'b1);
			if (host_we) begin
				ref_write(host_adr, host_sel, host_dat_w);
			end else begin
				check_data("host_dat_r", host_dat_r, ref_read(host_adr));
			end
		end
	end

	// One Wishbone classic access, entered on a falling edge
	task automatic host_access(input logic we, input bus_addr_t adr, input bus_sel_t sel,
			input bus_data_t dat);
		host_cyc = 1'b1;
		host_stb = 1'b1;
		host_we = we;
		host_adr = adr;
		host_sel = sel;
		host_dat_w = dat;
		acks_issued++;
		// Request held, the arbiter may stall it
		do begin
			@(negedge clock_main);
		end while (!host_ack);
		// Ack cycle closes at the next rising edge
		@(negedge clock_main);
		host_cyc = 1'b0;
		host_stb = 1'b0;
		host_we = 1'b0;
	endtask

	task automatic host_write(input bus_addr_t adr, input bus_sel_t sel, input bus_data_t dat);
		host_access(1'b1, adr, sel, dat);
	endtask

	task automatic host_read(input bus_addr_t adr);
		host_access(1'b0, adr, 4'hf, '0);
	endtask

	task automatic begin_test();
		err_mark = err_count;
		acks_seen = 0;
		acks_issued = 0;
	endtask

	task automatic end_test(input string name);
		// Every access ended by exactly one ack
		check_count("host_ack count", acks_seen, acks_issued);
		tests_run++;
		if (err_count != err_mark) begin
			tests_failed++;
			$display("test %0d %s: failed", tests_run, name);
		end else begin
			$display("test %0d %s: ok", tests_run, name);
		end
	endtask

	initial begin
		bus_addr_t adr;
		bus_addr_t base;
		bus_sel_t sel;
		bus_sel_t masks [4];
		int w;
		bit is_write;
		host_cyc = 1'b0;
		host_stb = 1'b0;
		host_we = 1'b0;
		host_adr = '0;
		host_sel = '0;
		host_dat_w = '0;
		err_count = 0;
		checks_done = 0;
		tests_run = 0;
		tests_failed = 0;
		masks = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
		for (int i = 0; i < REF_WORDS; i++) begin
			ref_known[i] = 1'b0;
		end
		// Boot image as the loader should leave it
		for (int i = 0; i < `SOC_BOOT_WORDS; i++) begin
			adr = bus_addr_t'(`SOC_BOOT_BASE) + bus_addr_t'(4 * i);
			ref_mem[adr[12:2]] = image_word(i);
			ref_known[adr[12:2]] = 1'b1;
		end
		void'($urandom(SEED));
		wait (rst_n === 1'b1);
		// Loader takes the bus at the first edge out of reset
		@(negedge clock_main);

		// Host read issued while the copy is still running
		begin_test();
		check_flag("boot_done", boot_done, 1'b0);
		host_read(bus_addr_t'(`SOC_BOOT_BASE) + 32'd12);
		end_test("stall during boot");

		begin_test();
		check_flag("boot_done", boot_done, 1'b1);
		for (int i = 0; i < `SOC_BOOT_WORDS; i++) begin
			host_read(bus_addr_t'(`SOC_BOOT_BASE) + bus_addr_t'(4 * i));
		end
		end_test("boot image");

		// Rows 16 and up, clear of the image
		begin_test();
		for (int i = 0; i < FILL_WORDS; i++) begin
			host_write(32'h80 + bus_addr_t'(4 * i), 4'hf, $urandom());
		end
		for (int i = 0; i < FILL_WORDS; i++) begin
			host_read(32'h80 + bus_addr_t'(4 * i));
		end
		end_test("full word write and read");

		begin_test();
		for (int k = 0; k < 2; k++) begin
			base = 32'hc0 + bus_addr_t'(4 * k);
			host_write(base, 4'hf, 32'ha5a5_5a5a);
			for (int m = 0; m < 4; m++) begin
				host_write(base, masks[m], $urandom());
				host_read(base);
			end
		end
		end_test("byte masks");

		// Both halves of row 40
		begin_test();
		host_write(32'h140, 4'hf, 32'h1111_2222);
		host_write(32'h144, 4'hf, 32'h3333_4444);
		host_read(32'h140);
		host_read(32'h144);
		host_write(32'h140, 4'hf, 32'h5555_6666);
		host_read(32'h144);
		end_test("lane independence");

		// High address bits random, so wrapped copies of low rows get hit
		begin_test();
		for (int n = 0; n < RAND_OPS; n++) begin
			w = $urandom_range(RAND_SPAN - 1);
			adr = ($urandom() & 32'hffff_e000) | bus_addr_t'(w << 2) | ($urandom() & 32'h3);
			sel = bus_sel_t'($urandom_range(15, 1));
			is_write = $urandom_range(1);
			// Unwritten word gets a full write first
			if (!ref_known[adr[12:2]]) begin
				is_write = 1'b1;
				sel = 4'hf;
			end
			if (is_write) begin
				host_write(adr, sel, $urandom());
			end else begin
				host_read(adr);
			end
		end
		end_test("random mix");

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks_done, err_count);
		if (err_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// Bound on the whole run, 3 cycles per access plus margin
	initial begin
		#(TIMEOUT_NS);
		$display("timeout: tests did not finish within %0d ns", TIMEOUT_NS);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* build.f */
+incdir+rtl
rtl/soc_pkg.sv
rtl/mem_bus_if.sv
rtl/iboot_loader.sv
rtl/mem_arbiter.sv
rtl/main_ram.sv
rtl/soc_top.sv
test/clock_gen.sv
test/tb_soc.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -Wno-fatal -j 0
TOP      = tb_soc
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Simulation finished: FAIL

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for failure"
	@echo "  clean  remove build output and the log"
	@echo "  help   list these targets"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
